// File: common/core_pkg.sv
package core_pkg;

    localparam int reg_addr_w = 5;
    localparam int data_w     = 32;

    typedef logic [5:0] opcode_t;

    // ========================================
    // opcodes
    // ========================================
    localparam opcode_t op_nop  = 6'h00;
    localparam opcode_t op_add  = 6'h01;
    localparam opcode_t op_sub  = 6'h02;
    localparam opcode_t op_and  = 6'h03;
    localparam opcode_t op_or   = 6'h04;
    localparam opcode_t op_xor  = 6'h05;
    localparam opcode_t op_addi = 6'h06;
    // byte device, upper lane only
    localparam opcode_t op_in   = 6'h10;
    localparam opcode_t op_out  = 6'h11;

    // ========================================
    // lane instruction formats
    // ========================================
    typedef struct packed {
        opcode_t                 opcode;
        logic [reg_addr_w-1:0]   rd;
        logic [reg_addr_w-1:0]   rs;
        logic [reg_addr_w-1:0]   rt;
        logic [10:0]             unused;
    } r_form_t;

    typedef struct packed {
        opcode_t                 opcode;
        logic [reg_addr_w-1:0]   rd;
        logic [reg_addr_w-1:0]   rs;
        logic [15:0]             imm;
    } i_form_t;

    // same word, read as R or I depending on opcode
    typedef union packed {
        r_form_t r;
        i_form_t i;
    } lane_inst_u;

    typedef enum logic [2:0] {
        alu_pass,
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor
    } alu_op_t;

endpackage

// File: common/lane_if.sv
interface lane_if;
    import core_pkg::*;

    logic                  valid;
    alu_op_t               op;
    logic [reg_addr_w-1:0] rd;
    logic                  wen;
    logic [data_w-1:0]     srca;
    logic [data_w-1:0]     srcb;

    modport producer (
        output valid, op, rd, wen, srca, srcb
    );

    modport consumer (
        input valid, op, rd, wen, srca, srcb
    );

endinterface

// File: execute/lane_alu.sv
module lane_alu (
    input  core_pkg::alu_op_t               op,
    input  logic [core_pkg::data_w-1:0]     srca,
    input  logic [core_pkg::data_w-1:0]     srcb,
    output logic [core_pkg::data_w-1:0]     result
);
    import core_pkg::*;

    always_comb begin
        case (op)
            alu_add: begin
                result = srca + srcb;
            end
            alu_sub: begin
                result = srca - srcb;
            end
            alu_and: begin
                result = srca & srcb;
            end
            alu_or: begin
                result = srca | srcb;
            end
            alu_xor: begin
                result = srca ^ srcb;
            end
            // nop, in and out
            default: begin
                result = srca;
            end
        endcase
    end

endmodule

// File: execute/execute_stage.sv
module execute_stage (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic [7:0]                        io_byte,
    lane_if.consumer                          lane_u,
    lane_if.consumer                          lane_l,
    output logic                              wb_u_en,
    output logic [core_pkg::reg_addr_w-1:0]   wb_u_rd,
    output logic [core_pkg::data_w-1:0]       wb_u_data,
    output logic                              wb_l_en,
    output logic [core_pkg::reg_addr_w-1:0]   wb_l_rd,
    output logic [core_pkg::data_w-1:0]       wb_l_data
);
    import core_pkg::*;

    logic [data_w-1:0] u_result;
    logic [data_w-1:0] l_result;
    logic              u_is_read;

    lane_alu u_alu_u (
        .op     (lane_u.op),
        .srca   (lane_u.srca),
        .srcb   (lane_u.srcb),
        .result (u_result)
    );

    lane_alu u_alu_l (
        .op     (lane_l.op),
        .srca   (lane_l.srca),
        .srcb   (lane_l.srcb),
        .result (l_result)
    );

    // pass with a write only comes from op_in
    assign u_is_read = (lane_u.op == alu_pass) && lane_u.wen;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_u_en <= 1'b0;
            wb_l_en <= 1'b0;
        end else begin
            wb_u_en <= lane_u.valid && lane_u.wen;
            wb_l_en <= lane_l.valid && lane_l.wen;
        end
    end

    always_ff @(posedge clk) begin
        wb_u_rd   <= lane_u.rd;
        wb_l_rd   <= lane_l.rd;
        wb_u_data <= u_is_read ? {{(data_w-8){1'b0}}, io_byte} : u_result;
        wb_l_data <= l_result;
    end

endmodule

// File: source/register_file.sv
module register_file (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              wr_u_en,
    input  logic [core_pkg::reg_addr_w-1:0]   wr_u_rd,
    input  logic [core_pkg::data_w-1:0]       wr_u_data,
    input  logic                              wr_l_en,
    input  logic [core_pkg::reg_addr_w-1:0]   wr_l_rd,
    input  logic [core_pkg::data_w-1:0]       wr_l_data,
    input  logic [core_pkg::reg_addr_w-1:0]   rd_addr_ua,
    input  logic [core_pkg::reg_addr_w-1:0]   rd_addr_ub,
    input  logic [core_pkg::reg_addr_w-1:0]   rd_addr_la,
    input  logic [core_pkg::reg_addr_w-1:0]   rd_addr_lb,
    output logic [core_pkg::data_w-1:0]       rd_data_ua,
    output logic [core_pkg::data_w-1:0]       rd_data_ub,
    output logic [core_pkg::data_w-1:0]       rd_data_la,
    output logic [core_pkg::data_w-1:0]       rd_data_lb,
    output logic [7:0]                        led
);
    import core_pkg::*;

    logic [data_w-1:0] regs [0:(1 << reg_addr_w)-1];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < (1 << reg_addr_w); i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr_u_en) begin
                regs[wr_u_rd] <= wr_u_data;
            end
            // lower port last, so it wins on the same rd
            if (wr_l_en) begin
                regs[wr_l_rd] <= wr_l_data;
            end
        end
    end

    assign rd_data_ua = regs[rd_addr_ua];
    assign rd_data_ub = regs[rd_addr_ub];
    assign rd_data_la = regs[rd_addr_la];
    assign rd_data_lb = regs[rd_addr_lb];

    assign led = regs[0][7:0];

endmodule

// File: source/io_port_ctrl.sv
module io_port_ctrl (
    input  logic       clk,
    input  logic       rstn,
    input  logic       io_req,
    input  logic       io_read,
    input  logic [7:0] io_wbyte,
    input  logic       io_rbusy,
    input  logic       io_rdone,
    input  logic [7:0] io_rdata,
    input  logic       io_wbusy,
    input  logic       io_wdone,
    output logic       io_ren,
    output logic       io_wen,
    output logic [7:0] io_wdata,
    output logic       io_done,
    output logic [7:0] io_byte
);

    localparam logic [2:0] st_idle       = 3'd0;
    localparam logic [2:0] st_wait_read  = 3'd1;
    localparam logic [2:0] st_reading    = 3'd2;
    localparam logic [2:0] st_wait_write = 3'd3;
    localparam logic [2:0] st_writing    = 3'd4;

    logic [2:0] state;

    // ========================================
    // interlock FSM
    // ========================================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= st_idle;
            io_ren  <= 1'b0;
            io_wen  <= 1'b0;
            io_done <= 1'b0;
        end else begin
            // strobes and done are single-cycle pulses
            io_ren  <= 1'b0;
            io_wen  <= 1'b0;
            io_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (io_req) begin
                        state <= io_read ? st_wait_read : st_wait_write;
                    end
                end
                st_wait_read: begin
                    if (!io_rbusy) begin
                        io_ren <= 1'b1;
                        state  <= st_reading;
                    end
                end
                st_reading: begin
                    if (io_rdone) begin
                        io_done <= 1'b1;
                        state   <= st_idle;
                    end
                end
                st_wait_write: begin
                    if (!io_wbusy) begin
                        io_wen <= 1'b1;
                        state  <= st_writing;
                    end
                end
                st_writing: begin
                    if (io_wdone) begin
                        io_done <= 1'b1;
                        state   <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // byte latches
    always_ff @(posedge clk) begin
        if (state == st_idle && io_req && !io_read) begin
            io_wdata <= io_wbyte;
        end
        if (state == st_reading && io_rdone) begin
            io_byte <= io_rdata;
        end
    end

endmodule

// File: source/bundle_decode.sv
module bundle_decode (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              inst_valid,
    input  logic [63:0]                       inst_bundle,
    input  logic [core_pkg::data_w-1:0]       rd_data_ua,
    input  logic [core_pkg::data_w-1:0]       rd_data_ub,
    input  logic [core_pkg::data_w-1:0]       rd_data_la,
    input  logic [core_pkg::data_w-1:0]       rd_data_lb,
    input  logic                              fw_u_en,
    input  logic [core_pkg::reg_addr_w-1:0]   fw_u_rd,
    input  logic [core_pkg::data_w-1:0]       fw_u_data,
    input  logic                              fw_l_en,
    input  logic [core_pkg::reg_addr_w-1:0]   fw_l_rd,
    input  logic [core_pkg::data_w-1:0]       fw_l_data,
    input  logic                              io_done,
    output logic [core_pkg::reg_addr_w-1:0]   rd_addr_ua,
    output logic [core_pkg::reg_addr_w-1:0]   rd_addr_ub,
    output logic [core_pkg::reg_addr_w-1:0]   rd_addr_la,
    output logic [core_pkg::reg_addr_w-1:0]   rd_addr_lb,
    output logic                              stall,
    output logic                              io_req,
    output logic                              io_read,
    output logic [7:0]                        io_wbyte,
    lane_if.producer                          lane_u,
    lane_if.producer                          lane_l
);
    import core_pkg::*;

    logic        bundle_valid;
    logic [63:0] bundle_q;
    lane_inst_u  inst_u;
    lane_inst_u  inst_l;
    logic        upper_io;
    logic        hold;
    alu_op_t     u_op;
    alu_op_t     l_op;
    logic        u_wen;
    logic        l_wen;
    logic        u_imm;
    logic        l_imm;

    // execute lower beats execute upper beats register file
    function automatic logic [data_w-1:0] fwd(
        input logic [reg_addr_w-1:0] addr,
        input logic [data_w-1:0]     rf_data
    );
        if (fw_l_en && fw_l_rd == addr) return fw_l_data;
        if (fw_u_en && fw_u_rd == addr) return fw_u_data;
        return rf_data;
    endfunction

    function automatic void decode_lane(
        input  lane_inst_u inst,
        input  logic       upper,
        output alu_op_t    op,
        output logic       wen,
        output logic       use_imm
    );
        case (inst.r.opcode)
            op_add:  op = alu_add;
            op_sub:  op = alu_sub;
            op_and:  op = alu_and;
            op_or:   op = alu_or;
            op_xor:  op = alu_xor;
            op_addi: op = alu_add;
            default: op = alu_pass;
        endcase
        wen = (inst.r.opcode inside {op_add, op_sub, op_and, op_or, op_xor, op_addi})
            || (upper && inst.r.opcode == op_in);
        use_imm = (inst.r.opcode == op_addi);
    endfunction

    // ========================================
    // bundle register and interlock hold
    // ========================================
    assign inst_u   = bundle_q[63:32];
    assign inst_l   = bundle_q[31:0];
    assign upper_io = bundle_valid
        && (inst_u.r.opcode == op_in || inst_u.r.opcode == op_out);
    assign hold     = upper_io && !io_done;
    assign stall    = hold;
    assign io_req   = hold;
    assign io_read  = (inst_u.r.opcode == op_in);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            bundle_valid <= 1'b0;
        end else if (!hold) begin
            bundle_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold && inst_valid) begin
            bundle_q <= inst_bundle;
        end
    end

    // ========================================
    // operand reads
    // ========================================
    assign rd_addr_ua = inst_u.r.rs;
    assign rd_addr_ub = inst_u.r.rt;
    assign rd_addr_la = inst_l.r.rs;
    assign rd_addr_lb = inst_l.r.rt;

    always_comb begin
        decode_lane(inst_u, 1'b1, u_op, u_wen, u_imm);
        decode_lane(inst_l, 1'b0, l_op, l_wen, l_imm);
    end

    assign lane_u.valid = bundle_valid && !hold;
    assign lane_u.op    = u_op;
    assign lane_u.wen   = u_wen;
    assign lane_u.rd    = inst_u.r.rd;
    assign lane_u.srca  = fwd(rd_addr_ua, rd_data_ua);
    assign lane_u.srcb  = u_imm ? {{16{inst_u.i.imm[15]}}, inst_u.i.imm}
                                : fwd(rd_addr_ub, rd_data_ub);

    assign lane_l.valid = bundle_valid && !hold;
    assign lane_l.op    = l_op;
    assign lane_l.wen   = l_wen;
    assign lane_l.rd    = inst_l.r.rd;
    assign lane_l.srca  = fwd(rd_addr_la, rd_data_la);
    assign lane_l.srcb  = l_imm ? {{16{inst_l.i.imm[15]}}, inst_l.i.imm}
                                : fwd(rd_addr_lb, rd_data_lb);

    // byte for op_out, low byte of rs
    assign io_wbyte = lane_u.srca[7:0];

endmodule

// File: source/dual_lane_core.sv
module dual_lane_core (
    input  logic        clk,
    input  logic        rstn,
    input  logic        inst_valid,
    input  logic [63:0] inst_bundle,
    input  logic [7:0]  io_rdata,
    input  logic        io_rbusy,
    input  logic        io_rdone,
    input  logic        io_wbusy,
    input  logic        io_wdone,
    output logic        stall,
    output logic        io_ren,
    output logic        io_wen,
    output logic [7:0]  io_wdata,
    output logic        wb_u_en,
    output logic [4:0]  wb_u_rd,
    output logic [31:0] wb_u_data,
    output logic        wb_l_en,
    output logic [4:0]  wb_l_rd,
    output logic [31:0] wb_l_data,
    output logic [7:0]  led
);
    import core_pkg::*;

    logic [reg_addr_w-1:0] rd_addr_ua;
    logic [reg_addr_w-1:0] rd_addr_ub;
    logic [reg_addr_w-1:0] rd_addr_la;
    logic [reg_addr_w-1:0] rd_addr_lb;
    logic [data_w-1:0]     rd_data_ua;
    logic [data_w-1:0]     rd_data_ub;
    logic [data_w-1:0]     rd_data_la;
    logic [data_w-1:0]     rd_data_lb;
    logic                  io_req;
    logic                  io_read;
    logic [7:0]            io_wbyte;
    logic                  io_done;
    logic [7:0]            io_byte;

    lane_if lane_u ();
    lane_if lane_l ();

    bundle_decode u_bundle_decode (
        .clk(clk), .rstn(rstn), .inst_valid(inst_valid), .inst_bundle(inst_bundle),
        .rd_data_ua(rd_data_ua), .rd_data_ub(rd_data_ub),
        .rd_data_la(rd_data_la), .rd_data_lb(rd_data_lb),
        .fw_u_en(wb_u_en), .fw_u_rd(wb_u_rd), .fw_u_data(wb_u_data),
        .fw_l_en(wb_l_en), .fw_l_rd(wb_l_rd), .fw_l_data(wb_l_data),
        .io_done(io_done),
        .rd_addr_ua(rd_addr_ua), .rd_addr_ub(rd_addr_ub),
        .rd_addr_la(rd_addr_la), .rd_addr_lb(rd_addr_lb),
        .stall(stall), .io_req(io_req), .io_read(io_read), .io_wbyte(io_wbyte),
        .lane_u(lane_u.producer), .lane_l(lane_l.producer)
    );

    // execute outputs double as write-back and forward paths
    execute_stage u_execute_stage (
        .clk(clk), .rstn(rstn), .io_byte(io_byte),
        .lane_u(lane_u.consumer), .lane_l(lane_l.consumer),
        .wb_u_en(wb_u_en), .wb_u_rd(wb_u_rd), .wb_u_data(wb_u_data),
        .wb_l_en(wb_l_en), .wb_l_rd(wb_l_rd), .wb_l_data(wb_l_data)
    );

    register_file u_register_file (
        .clk(clk), .rstn(rstn),
        .wr_u_en(wb_u_en), .wr_u_rd(wb_u_rd), .wr_u_data(wb_u_data),
        .wr_l_en(wb_l_en), .wr_l_rd(wb_l_rd), .wr_l_data(wb_l_data),
        .rd_addr_ua(rd_addr_ua), .rd_addr_ub(rd_addr_ub),
        .rd_addr_la(rd_addr_la), .rd_addr_lb(rd_addr_lb),
        .rd_data_ua(rd_data_ua), .rd_data_ub(rd_data_ub),
        .rd_data_la(rd_data_la), .rd_data_lb(rd_data_lb),
        .led(led)
    );

    io_port_ctrl u_io_port_ctrl (
        .clk(clk), .rstn(rstn), .io_req(io_req), .io_read(io_read),
        .io_wbyte(io_wbyte), .io_rbusy(io_rbusy), .io_rdone(io_rdone),
        .io_rdata(io_rdata), .io_wbusy(io_wbusy), .io_wdone(io_wdone),
        .io_ren(io_ren), .io_wen(io_wen), .io_wdata(io_wdata),
        .io_done(io_done), .io_byte(io_byte)
    );

endmodule

// File: test/tb_checker.sv
module tb_checker (
    input logic        clk,
    input logic        rstn,
    input logic        inst_valid,
    input logic        stall,
    input logic        io_ren,
    input logic        io_wen,
    input logic [7:0]  io_wdata,
    input logic        wb_u_en,
    input logic [4:0]  wb_u_rd,
    input logic [31:0] wb_u_data,
    input logic        wb_l_en,
    input logic [4:0]  wb_l_rd,
    input logic [31:0] wb_l_data,
    input logic [7:0]  led
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_data_q [$];
    logic [7:0]  exp_byte_q [$];
    int          mismatch_cnt = 0;
    int          missing_cnt = 0;
    int          extra_cnt = 0;
    logic        seen_bundle;

    task automatic expect_write(input logic [4:0] rd, input logic [31:0] data);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(data);
    endtask

    task automatic expect_byte(input logic [7:0] data);
        exp_byte_q.push_back(data);
    endtask

    task automatic compare_write(input string lane, input logic [4:0] rd,
                                 input logic [31:0] data);
        logic [4:0]  erd;
        logic [31:0] edata;
        if (exp_rd_q.size() == 0) begin
            extra_cnt++;
            $display("unexpected write on the %s lane to register %0d", lane, rd);
        end else begin
            erd   = exp_rd_q.pop_front();
            edata = exp_data_q.pop_front();
            if (rd !== erd) begin
                mismatch_cnt++;
                $display("Fail wb_%s_rd: got %h expected %h", lane, rd, erd);
            end
            if (data !== edata) begin
                mismatch_cnt++;
                $display("Fail wb_%s_data: got %h expected %h", lane, data, edata);
            end
        end
    endtask

    // quiet outputs until the first bundle arrives
    always @(posedge clk) begin
        if (!rstn) begin
            seen_bundle <= 1'b0;
        end else if (inst_valid) begin
            seen_bundle <= 1'b1;
        end
        if (rstn && seen_bundle === 1'b0) begin
            if (stall || io_ren || io_wen || wb_u_en || wb_l_en) begin
                mismatch_cnt++;
                $display("a control output went high before any bundle was sent");
            end
            if (led !== 8'h00) begin
                mismatch_cnt++;
                $display("Fail led: got %h expected %h", led, 8'h00);
            end
        end
    end

    // ========================================
    // write-back and output byte compare
    // ========================================
    always @(posedge clk) begin
        if (rstn) begin
            if (wb_u_en) begin
                compare_write("u", wb_u_rd, wb_u_data);
            end
            if (wb_l_en) begin
                compare_write("l", wb_l_rd, wb_l_data);
            end
            if (io_wen) begin
                if (exp_byte_q.size() == 0) begin
                    extra_cnt++;
                    $display("unexpected output byte %h on the device", io_wdata);
                end else if (io_wdata !== exp_byte_q[0]) begin
                    mismatch_cnt++;
                    $display("Fail io_wdata: got %h expected %h", io_wdata, exp_byte_q[0]);
                    void'(exp_byte_q.pop_front());
                end else begin
                    void'(exp_byte_q.pop_front());
                end
            end
        end
    end

    task automatic final_check(input logic [7:0] exp_led);
        if (exp_rd_q.size() != 0 || exp_byte_q.size() != 0) begin
            missing_cnt += exp_rd_q.size() + exp_byte_q.size();
            $display("%0d expected writes and %0d expected bytes never arrived",
                     exp_rd_q.size(), exp_byte_q.size());
        end
        if (led !== exp_led) begin
            mismatch_cnt++;
            $display("Fail led: got %h expected %h", led, exp_led);
        end
    endtask

endmodule

// File: test/tb_top.sv
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;
    import core_pkg::*;

    localparam int directed_cnt    = 17;
    localparam int random_cnt      = 300;
    localparam int watchdog_cycles = (directed_cnt + random_cnt) * 12 + 100;
    localparam int table_len       = 512;

    logic        clk;
    logic        rstn;
    logic        inst_valid;
    logic [63:0] inst_bundle;
    logic [7:0]  io_rdata;
    logic        io_rbusy;
    logic        io_rdone;
    logic        io_wbusy;
    logic        io_wdone;
    logic        stall;
    logic        io_ren;
    logic        io_wen;
    logic [7:0]  io_wdata;
    logic        wb_u_en;
    logic [4:0]  wb_u_rd;
    logic [31:0] wb_u_data;
    logic        wb_l_en;
    logic [4:0]  wb_l_rd;
    logic [31:0] wb_l_data;
    logic [7:0]  led;

    logic [31:0] model_regs [0:31];
    logic [7:0]  rbytes [0:table_len-1];
    int          done_dly [0:table_len-1];
    int          busy_dly [0:table_len-1];
    logic [63:0] rand_bundles [0:random_cnt-1];
    logic [31:0] rng;
    int          in_cnt;
    int          read_cnt;
    int          xfer_cnt;

    dual_lane_core u_dual_lane_core (.*);

    tb_checker u_checker (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] r_inst(input opcode_t op, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt);
        return {op, rd, rs, rt, 11'h000};
    endfunction

    function automatic logic [31:0] i_inst(input opcode_t op, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [15:0] imm);
        return {op, rd, rs, imm};
    endfunction

    // reference result of one lane
    function automatic logic [31:0] ref_result(input opcode_t op, input logic [31:0] a,
                                               input logic [31:0] b, input logic [15:0] imm,
                                               input logic [7:0] in_byte);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_addi: return a + {{16{imm[15]}}, imm};
            op_in:   return {24'h000000, in_byte};
            default: return a;
        endcase
    endfunction

    task automatic model_bundle(input logic [63:0] b);
        logic [31:0] inst;
        opcode_t     op;
        logic [31:0] res [0:1];
        logic        wr [0:1];
        logic [7:0]  in_byte;
        in_byte = 8'h00;
        if (b[63:58] == op_in) begin
            in_byte = rbytes[in_cnt];
            in_cnt++;
        end
        if (b[63:58] == op_out) begin
            u_checker.expect_byte(model_regs[b[52:48]][7:0]);
        end
        // both lanes read the registers as they were before the bundle
        for (int k = 0; k < 2; k++) begin
            inst   = (k == 0) ? b[63:32] : b[31:0];
            op     = inst[31:26];
            wr[k]  = (op inside {op_add, op_sub, op_and, op_or, op_xor, op_addi})
                || (k == 0 && op == op_in);
            res[k] = ref_result(op, model_regs[inst[20:16]], model_regs[inst[15:11]],
                                inst[15:0], in_byte);
        end
        for (int k = 0; k < 2; k++) begin
            inst = (k == 0) ? b[63:32] : b[31:0];
            if (wr[k]) begin
                u_checker.expect_write(inst[25:21], res[k]);
                model_regs[inst[25:21]] = res[k];
            end
        end
    endtask

    // present a bundle and return right after the edge that accepts it
    task automatic send(input logic [31:0] upper, input logic [31:0] lower);
        logic accepted;
        inst_bundle <= {upper, lower};
        inst_valid  <= 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = !stall;
            @(posedge clk);
        end
        model_bundle({upper, lower});
    endtask

    function automatic logic [31:0] rand_lane(input logic [31:0] r);
        opcode_t op;
        case (r[31:28] % 4'd10)
            4'd0:    op = op_nop;
            4'd1:    op = op_add;
            4'd2:    op = op_sub;
            4'd3:    op = op_and;
            4'd4:    op = op_or;
            4'd5:    op = op_xor;
            4'd8:    op = op_in;
            4'd9:    op = op_out;
            default: op = op_addi;
        endcase
        return {op, 2'b00, r[2:0], 2'b00, r[5:3], r[21:6]};
    endfunction

    // ========================================
    // byte device model
    // ========================================
    initial begin : read_device
        forever begin
            @(negedge clk);
            if (io_ren) begin
                repeat (done_dly[xfer_cnt]) @(posedge clk);
                io_rdata <= rbytes[read_cnt];
                io_rdone <= 1'b1;
                read_cnt++;
                @(posedge clk);
                io_rdone <= 1'b0;
                io_rbusy <= (busy_dly[xfer_cnt] > 0);
                repeat (busy_dly[xfer_cnt]) @(posedge clk);
                io_rbusy <= 1'b0;
                xfer_cnt++;
            end
        end
    end

    initial begin : write_device
        forever begin
            @(negedge clk);
            if (io_wen) begin
                repeat (done_dly[xfer_cnt]) @(posedge clk);
                io_wdone <= 1'b1;
                @(posedge clk);
                io_wdone <= 1'b0;
                io_wbusy <= (busy_dly[xfer_cnt] > 0);
                repeat (busy_dly[xfer_cnt]) @(posedge clk);
                io_wbusy <= 1'b0;
                xfer_cnt++;
            end
        end
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("sim failed");
        $finish;
    end

    initial begin : stimulus
        clk         = 1'b0;
        rstn        = 1'b0;
        inst_valid  = 1'b0;
        inst_bundle = '0;
        io_rdata    = 8'h00;
        io_rbusy    = 1'b0;
        io_rdone    = 1'b0;
        io_wbusy    = 1'b0;
        io_wdone    = 1'b0;
        in_cnt      = 0;
        read_cnt    = 0;
        xfer_cnt    = 0;
        rng         = 32'h5b7f;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < table_len; i++) begin
            rng         = lcg(rng);
            rbytes[i]   = rng[23:16];
            done_dly[i] = 1 + int'(rng[31:24] % 8'd5);
            busy_dly[i] = int'(rng[9:8]);
        end
        for (int i = 0; i < random_cnt; i++) begin
            rng             = lcg(rng);
            rand_bundles[i][63:32] = rand_lane(rng);
            rng             = lcg(rng);
            rand_bundles[i][31:0]  = rand_lane(rng);
        end

        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        // idle stretch, outputs must stay quiet
        repeat (6) @(posedge clk);

        send(i_inst(op_addi, 5'd1, 5'd0, 16'hfffb), i_inst(op_addi, 5'd2, 5'd0, 16'h7fff));
        send(r_inst(op_add, 5'd3, 5'd1, 5'd2), r_inst(op_sub, 5'd4, 5'd1, 5'd2));
        send(r_inst(op_and, 5'd5, 5'd3, 5'd1), r_inst(op_or, 5'd6, 5'd4, 5'd2));
        send(r_inst(op_xor, 5'd7, 5'd5, 5'd6), i_inst(op_addi, 5'd8, 5'd7, 16'h8000));
        send(i_inst(op_addi, 5'd9, 5'd1, 16'h8000), r_inst(op_sub, 5'd10, 5'd0, 5'd1));
        send(r_inst(op_add, 5'd18, 5'd2, 5'd2), r_inst(op_sub, 5'd19, 5'd10, 5'd9));
        // same rd in both lanes, lower wins
        send(i_inst(op_addi, 5'd11, 5'd0, 16'h0001), i_inst(op_addi, 5'd11, 5'd0, 16'h0002));
        send(r_inst(op_add, 5'd12, 5'd11, 5'd11), r_inst(op_nop, 5'd0, 5'd0, 5'd0));
        send(r_inst(op_nop, 5'd0, 5'd0, 5'd0), r_inst(op_nop, 5'd0, 5'd0, 5'd0));
        send(r_inst(op_add, 5'd13, 5'd11, 5'd0), r_inst(op_nop, 5'd0, 5'd0, 5'd0));
        send(r_inst(op_in, 5'd14, 5'd0, 5'd0), r_inst(op_nop, 5'd0, 5'd0, 5'd0));
        send(r_inst(op_add, 5'd15, 5'd14, 5'd14), r_inst(op_in, 5'd20, 5'd0, 5'd0));
        send(i_inst(op_addi, 5'd16, 5'd0, 16'h00a5), r_inst(op_nop, 5'd0, 5'd0, 5'd0));
        // out byte comes from the forward path
        send(r_inst(op_out, 5'd0, 5'd16, 5'd0), r_inst(op_out, 5'd0, 5'd1, 5'd0));
        send(r_inst(op_in, 5'd0, 5'd0, 5'd0), r_inst(op_add, 5'd17, 5'd0, 5'd1));
        send(r_inst(op_out, 5'd0, 5'd0, 5'd0), r_inst(op_nop, 5'd0, 5'd0, 5'd0));
        send(i_inst(op_addi, 5'd0, 5'd0, 16'h0042), r_inst(op_nop, 5'd0, 5'd0, 5'd0));

        for (int i = 0; i < random_cnt; i++) begin
            send(rand_bundles[i][63:32], rand_bundles[i][31:0]);
        end
        inst_valid <= 1'b0;
        // a held IO bundle drains first, then two edges to the register file
        @(negedge clk);
        while (stall) begin
            @(negedge clk);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        u_checker.final_check(model_regs[0][7:0]);

        $display("errors: %0d mismatched, %0d missing, %0d extra",
                 u_checker.mismatch_cnt, u_checker.missing_cnt, u_checker.extra_cnt);
        if (u_checker.mismatch_cnt + u_checker.missing_cnt + u_checker.extra_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: sim.f
common/core_pkg.sv
common/lane_if.sv
execute/lane_alu.sv
execute/execute_stage.sv
source/register_file.sv
source/io_port_ctrl.sv
source/bundle_decode.sv
source/dual_lane_core.sv
test/tb_checker.sv
test/tb_top.sv

// File: run.sh
#!/bin/bash
# build and run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f sim.f --top-module tb_top -o tb_sim --Mdir obj_dir \
    > build.log 2>&1 && ./obj_dir/tb_sim > sim.log 2>&1 || echo "build or run error, see build.log"
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
